// ==== sources.f ====
src/uart_pkg.sv
src/baud_gen.sv
src/uart_rx.sv
src/echo_fifo.sv
src/seg_decoder.sv
src/uart_tx.sv
src/uart_echo_top.sv
dv/tb_uart_echo.sv

// ==== Makefile ====
# Verilator build and run for the uart echo testbench

SRCS := $(shell cat sources.f)

.PHONY: run clean

run: obj_dir/Vtb_uart_echo
	./obj_dir/Vtb_uart_echo | tee /dev/stderr | grep -q "^test passed$$"

obj_dir/Vtb_uart_echo: sources.f $(SRCS)
	verilator --binary --timing --assert -f sources.f --top-module tb_uart_echo

clean:
	rm -rf obj_dir

// ==== dv/tb_uart_echo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart echo testbench
// drives serial frames into rxd, watches the echo
// on txd and checks status flags and the display
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module tb_uart_echo;

  timeunit 1ns;
  timeprecision 1ps;

  import uart_pkg::*;

  localparam int bit_clks   = os_div * os_rate;  // clocks per serial bit
  localparam int frame_clks = 12 * bit_clks;

  // active low gfedcba glyphs for 0..f
  localparam seg_t glyph_tab [16] = '{
    8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
    8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e
  };

  logic    clock = 1'b0;
  logic    arst_n, rx_en, nstop, rxd;
  parity_t parity_type;
  seg_t    hexa;
  logic    txd, tx_rdy, data_valid, frame_error, parity_error;

  uart_echo_top uut (
    .clock(clock), .arst_n(arst_n), .rx_en(rx_en), .parity_type(parity_type),
    .nstop(nstop), .rxd(rxd), .hexa(hexa), .txd(txd), .tx_rdy(tx_rdy),
    .data_valid(data_valid), .frame_error(frame_error), .parity_error(parity_error)
  );

  always #10 clock = ~clock;

  // parity bit that makes the total count of ones even or odd
  function automatic bit par_ref(input byte_t d, input parity_t pt);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      if (d[i]) ones++;
    end
    if (pt == 2'd3) return (ones % 2) == 0;
    return (ones % 2) == 1;
  endfunction

  function automatic seg_t seg_ref(input byte_t c);
    logic [3:0] nib;
    if (c inside {[8'h30:8'h39]}) nib = 4'(c - 8'h30);       // digits
    else if (c inside {[8'h41:8'h46]}) nib = 4'(c - 8'h37);  // upper case
    else if (c inside {[8'h61:8'h66]}) nib = 4'(c - 8'h57);  // lower case
    else return 8'hbf;  // dash
    return glyph_tab[nib];
  endfunction

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      $display("Error at %0d ns: %s got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_seg(input seg_t got, input seg_t exp, input string what);
    if (got !== exp) begin
      $display("Error at %0d ns: %s got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input bit got, input bit exp, input string what);
    if (got !== exp) begin
      $display("Error at %0d ns: %s got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic set_cfg(input parity_t pt, input logic ns);
    @(negedge clock);
    parity_type = pt;
    nstop       = ns;
  endtask

  task automatic drive_bit(input logic b);
    rxd = b;
    repeat (bit_clks) @(negedge clock);
  endtask

  // one frame on rxd with an optional wrong parity bit or low stop bit
  task automatic send_frame(input byte_t d, input bit bad_par, input bit bad_stop);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(d[i]);
    if (parity_type[1]) drive_bit(par_ref(d, parity_type) ^ bad_par);
    drive_bit(!bad_stop);
    if (nstop) drive_bit(1'b1);
    rxd = 1'b1;
  endtask

  task automatic recv_frame(output byte_t d, output bit par, output bit [1:0] stops);
    int n;
    n = 0;
    while (txd !== 1'b0) begin
      @(negedge clock);
      n++;
      if (n > 2 * frame_clks) begin
        $display("timeout waiting for a start bit on txd");
        abort_run();
      end
    end
    repeat (bit_clks / 2) @(negedge clock);  // middle of the start bit
    check_flag(txd, 1'b0, "txd start bit");
    for (int i = 0; i < 8; i++) begin
      repeat (bit_clks) @(negedge clock);
      d[i] = txd;
    end
    par   = 1'b0;
    stops = 2'b11;
    if (parity_type[1]) begin
      repeat (bit_clks) @(negedge clock);
      par = txd;
    end
    repeat (bit_clks) @(negedge clock);
    stops[0] = txd;
    if (nstop) begin
      repeat (bit_clks) @(negedge clock);
      stops[1] = txd;
    end
  endtask

  // half a bit remains after the last stop sample
  task automatic wait_tx_idle();
    int n;
    n = 0;
    while (tx_rdy !== 1'b1) begin
      @(negedge clock);
      n++;
      if (n > bit_clks) begin
        $display("tx_rdy did not return high after the echoed frame");
        abort_run();
      end
    end
  endtask

  task automatic check_quiet(input int clks);
    for (int i = 0; i < clks; i++) begin
      @(negedge clock);
      if (txd !== 1'b1) begin
        $display("unexpected frame on txd at %0d ns", $time);
        abort_run();
      end
    end
  endtask

  task automatic echo_byte(input byte_t d);
    byte_t      got;
    bit         par;
    bit [1:0]   st;
    fork
      send_frame(d, 1'b0, 1'b0);
      recv_frame(got, par, st);
    join
    check_byte(got, d, "echoed byte");
    if (parity_type[1]) check_flag(par, par_ref(d, parity_type), "echoed parity bit");
    check_flag(st[0], 1'b1, "first stop bit");
    if (nstop) check_flag(st[1], 1'b1, "second stop bit");
    check_flag(data_valid, 1'b1, "data_valid");
    wait_tx_idle();
  endtask

  task automatic plain_echo();
    set_cfg(2'd0, 1'b0);
    repeat (6) echo_byte(byte_t'($urandom()));
  endtask

  task automatic parity_echo();
    set_cfg(2'd2, 1'b1);  // even
    repeat (2) echo_byte(byte_t'($urandom()));
    set_cfg(2'd3, 1'b1);  // odd
    repeat (2) echo_byte(byte_t'($urandom()));
  endtask

  task automatic bad_parity_drop();
    set_cfg(2'd2, 1'b0);
    send_frame(byte_t'($urandom()), 1'b1, 1'b0);
    check_flag(parity_error, 1'b1, "parity_error on bad parity");
    check_flag(data_valid, 1'b0, "data_valid on bad parity");
    check_quiet(2 * frame_clks);
  endtask

  task automatic low_stop_drop();
    set_cfg(2'd0, 1'b0);
    send_frame(byte_t'($urandom()), 1'b0, 1'b1);
    check_flag(frame_error, 1'b1, "frame_error on low stop");
    check_flag(data_valid, 1'b0, "data_valid on low stop");
    check_quiet(2 * frame_clks);  // also gives rxd an idle gap
    echo_byte(byte_t'($urandom()));
    check_flag(frame_error, 1'b0, "frame_error after good frame");
    check_flag(parity_error, 1'b0, "parity_error after good frame");
  endtask

  task automatic display_glyphs();
    byte_t chars [4];
    chars = '{8'h37, 8'h62, 8'h46, 8'h78};  // 7 b F x
    set_cfg(2'd0, 1'b0);
    foreach (chars[i]) begin
      echo_byte(chars[i]);
      check_flag(hexa[7], 1'b1, "decimal point");
      check_seg(hexa, seg_ref(chars[i]), "hexa pattern");
    end
    send_frame(8'h41, 1'b0, 1'b1);
    check_quiet(2 * frame_clks);
    check_seg(hexa, seg_ref(8'h78), "hexa after invalid frame");
  endtask

  task automatic disabled_then_burst();
    byte_t    burst [3];
    byte_t    got [3];
    bit       par;
    bit [1:0] st;
    @(negedge clock);
    rx_en = 1'b0;
    // a hex digit would change the display if it got through
    send_frame(8'h35, 1'b0, 1'b0);
    check_quiet(2 * frame_clks);
    // status stays as the bad 'A' frame left it
    check_flag(data_valid, 1'b0, "data_valid while disabled");
    check_flag(frame_error, 1'b1, "frame_error while disabled");
    check_flag(parity_error, 1'b0, "parity_error while disabled");
    check_seg(hexa, seg_ref(8'h78), "hexa while disabled");
    rx_en = 1'b1;
    foreach (burst[i]) burst[i] = byte_t'($urandom());
    fork
      begin
        foreach (burst[i]) send_frame(burst[i], 1'b0, 1'b0);
      end
      begin
        for (int i = 0; i < 3; i++) recv_frame(got[i], par, st);
      end
    join
    foreach (burst[i]) check_byte(got[i], burst[i], "burst echo");
    wait_tx_idle();
  endtask

  initial begin
    arst_n      = 1'b0;
    rx_en       = 1'b1;
    parity_type = 2'd0;
    nstop       = 1'b0;
    rxd         = 1'b1;
    void'($urandom(32'h889d_4ee1));
    repeat (8) @(negedge clock);
    arst_n = 1'b1;
    check_flag(txd, 1'b1, "txd after reset");
    check_flag(tx_rdy, 1'b1, "tx_rdy after reset");
    check_flag(data_valid, 1'b0, "data_valid after reset");
    check_flag(frame_error, 1'b0, "frame_error after reset");
    check_flag(parity_error, 1'b0, "parity_error after reset");
    check_seg(hexa, 8'hff, "hexa after reset");  // blank
    plain_echo();
    parity_echo();
    bad_parity_drop();
    low_stop_drop();
    display_glyphs();
    disabled_then_burst();
    $display("test passed");
    $finish;
  end

endmodule

// ==== src/uart_echo_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart echo top level
// receiver, echo queue, display and transmitter
// on one clock with a shared 16x tick
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module uart_echo_top (
  input  logic              clock,
  input  logic              arst_n,
  input  logic              rx_en,
  input  uart_pkg::parity_t parity_type,
  input  logic              nstop,
  input  logic              rxd,
  output uart_pkg::seg_t    hexa,
  output logic              txd,
  output logic              tx_rdy,
  output logic              data_valid,
  output logic              frame_error,
  output logic              parity_error
);

  import uart_pkg::*;

  logic  os_tick, rx_done, fifo_empty, fifo_pop;
  byte_t rx_byte, fifo_data;

  baud_gen u_baud (.clock(clock), .arst_n(arst_n), .os_tick(os_tick));

  uart_rx u_rx (
    .clock(clock), .arst_n(arst_n), .os_tick(os_tick), .rx_en(rx_en),
    .parity_type(parity_type), .nstop(nstop), .rxd(rxd), .rx_byte(rx_byte),
    .rx_done(rx_done), .data_valid(data_valid), .frame_error(frame_error),
    .parity_error(parity_error)
  );

  echo_fifo u_fifo (
    .clock(clock), .arst_n(arst_n), .wr_byte(rx_byte), .rx_done(rx_done),
    .data_valid(data_valid), .fifo_pop(fifo_pop), .fifo_data(fifo_data),
    .fifo_empty(fifo_empty)
  );

  seg_decoder u_seg (
    .clock(clock), .arst_n(arst_n), .ascii(rx_byte), .rx_done(rx_done),
    .data_valid(data_valid), .hexa(hexa)
  );

  // transmitter shares the receiver enable
  uart_tx u_tx (
    .clock(clock), .arst_n(arst_n), .os_tick(os_tick), .tx_en(rx_en),
    .parity_type(parity_type), .nstop(nstop), .fifo_data(fifo_data),
    .fifo_empty(fifo_empty), .fifo_pop(fifo_pop), .txd(txd), .tx_rdy(tx_rdy)
  );

endmodule

// ==== src/uart_tx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart transmitter
// pops the echo queue and frames each byte,
// sixteen ticks per bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module uart_tx (
  input  logic              clock,
  input  logic              arst_n,
  input  logic              os_tick,
  input  logic              tx_en,
  input  uart_pkg::parity_t parity_type,
  input  logic              nstop,
  input  uart_pkg::byte_t   fifo_data,
  input  logic              fifo_empty,
  output logic              fifo_pop,
  output logic              txd,
  output logic              tx_rdy
);

  import uart_pkg::*;

  typedef enum logic [2:0] {s_idle, s_start, s_data, s_parity, s_stop} tx_state_t;

  tx_state_t  state;
  logic [3:0] tick_cnt;
  logic [2:0] bit_cnt;
  logic       stop_cnt;
  logic       armed;  // byte loaded and waiting for a tick
  byte_t      shreg;
  logic       par_bit;
  logic       par_on, bit_end;

  assign par_on  = (parity_type == par_even) || (parity_type == par_odd);
  assign bit_end = os_tick && (tick_cnt == 4'd15);
  assign tx_rdy  = (state == s_idle);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state    <= s_idle;
      txd      <= 1'b1;
      fifo_pop <= 1'b0;
      armed    <= 1'b0;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      stop_cnt <= 1'b0;
    end else begin
      fifo_pop <= 1'b0;
      if (os_tick && state != s_idle) tick_cnt <= tick_cnt + 1'b1;
      case (state)
        s_idle: begin
          if (fifo_pop) begin
            armed <= 1'b1;
          end else if (armed && os_tick) begin
            armed    <= 1'b0;
            txd      <= 1'b0;  // start bit
            tick_cnt <= '0;
            bit_cnt  <= '0;
            stop_cnt <= 1'b0;
            state    <= s_start;
          end else if (!armed && tx_en && !fifo_empty) begin
            fifo_pop <= 1'b1;
          end
        end
        s_start: if (bit_end) begin
          txd   <= shreg[0];
          state <= s_data;
        end
        s_data: if (bit_end) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt != 3'd7) begin
            txd <= shreg[1];
          end else if (par_on) begin
            txd   <= par_bit;
            state <= s_parity;
          end else begin
            txd   <= 1'b1;
            state <= s_stop;
          end
        end
        s_parity: if (bit_end) begin
          txd   <= 1'b1;
          state <= s_stop;
        end
        s_stop: if (bit_end) begin
          if (nstop && !stop_cnt) stop_cnt <= 1'b1;  // second stop bit
          else state <= s_idle;
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (fifo_pop) begin
      shreg   <= fifo_data;
      par_bit <= (^fifo_data) ^ (parity_type == par_odd);
    end else if (state == s_data && bit_end) begin
      shreg <= shreg >> 1;
    end
  end

  a_idle_high: assert property (@(posedge clock) disable iff (!arst_n)
    state == s_idle |-> txd);

endmodule

// ==== src/seg_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// seven segment decoder
// shows the last valid byte as a hex glyph
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module seg_decoder (
  input  logic            clock,
  input  logic            arst_n,
  input  uart_pkg::byte_t ascii,
  input  logic            rx_done,
  input  logic            data_valid,
  output uart_pkg::seg_t  hexa
);

  import uart_pkg::*;

  // active low gfedcba with the dp kept dark
  function automatic seg_t glyph(input byte_t c);
    logic [3:0] nib;
    logic       hex_ok;
    hex_ok = 1'b1;
    if (c >= "0" && c <= "9") nib = c[3:0];
    else if ((c >= "A" && c <= "F") || (c >= "a" && c <= "f")) nib = c[3:0] + 4'd9;
    else hex_ok = 1'b0;
    if (!hex_ok) return 8'hbf;  // dash from the middle segment only
    case (nib)
      4'h0: return 8'hc0;
      4'h1: return 8'hf9;
      4'h2: return 8'ha4;
      4'h3: return 8'hb0;
      4'h4: return 8'h99;
      4'h5: return 8'h92;
      4'h6: return 8'h82;
      4'h7: return 8'hf8;
      4'h8: return 8'h80;
      4'h9: return 8'h90;
      4'ha: return 8'h88;
      4'hb: return 8'h83;  // lower case b
      4'hc: return 8'hc6;
      4'hd: return 8'ha1;  // lower case d
      4'he: return 8'h86;
      default: return 8'h8e;
    endcase
  endfunction

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) hexa <= 8'hff;  // blank
    else if (rx_done && data_valid) hexa <= glyph(ascii);
  end

endmodule

// ==== src/echo_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// echo queue
// circular buffer of valid received bytes
// that drops writes past full
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module echo_fifo (
  input  logic            clock,
  input  logic            arst_n,
  input  uart_pkg::byte_t wr_byte,
  input  logic            rx_done,
  input  logic            data_valid,
  input  logic            fifo_pop,
  output uart_pkg::byte_t fifo_data,
  output logic            fifo_empty
);

  import uart_pkg::*;

  byte_t              mem [fifo_depth];
  logic [fifo_aw-1:0] wr_ptr, rd_ptr;  // wrap naturally at a power of two depth
  logic [fifo_aw:0]   count;
  logic               full, wr_en;

  assign full       = (count == fifo_depth[fifo_aw:0]);
  assign wr_en      = rx_done && data_valid && !full;
  assign fifo_empty = (count == '0);
  assign fifo_data  = mem[rd_ptr];  // head entry

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (fifo_pop) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, fifo_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) mem[wr_ptr] <= wr_byte;
  end

  a_no_pop_empty: assert property (@(posedge clock) disable iff (!arst_n)
    fifo_pop |-> !fifo_empty);

endmodule

// ==== src/uart_rx.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart receiver
// samples rxd mid-bit on the 16x tick, checks
// optional parity and one or two stop bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module uart_rx (
  input  logic              clock,
  input  logic              arst_n,
  input  logic              os_tick,
  input  logic              rx_en,
  input  uart_pkg::parity_t parity_type,
  input  logic              nstop,
  input  logic              rxd,
  output uart_pkg::byte_t   rx_byte,
  output logic              rx_done,
  output logic              data_valid,
  output logic              frame_error,
  output logic              parity_error
);

  import uart_pkg::*;

  typedef enum logic [2:0] {s_idle, s_start, s_data, s_parity, s_stop} rx_state_t;

  rx_state_t   state;
  logic        rxd_m, rxd_s, rxd_d;  // sync pair plus edge history
  logic [3:0]  tick_cnt;
  logic [2:0]  bit_cnt;
  logic        stop_cnt;
  byte_t       shreg;
  logic        par_acc, par_err, stop_err;
  logic        par_on, par_exp, bit_end, more_stop, stop_bad, last_stop;

  assign par_on    = (parity_type == par_even) || (parity_type == par_odd);
  assign par_exp   = par_acc ^ (parity_type == par_odd);
  assign bit_end   = os_tick && (tick_cnt == 4'd15);  // mid-point of the next bit
  assign more_stop = nstop && !stop_cnt;
  assign stop_bad  = stop_err || !rxd_s;
  assign last_stop = (state == s_stop) && bit_end && !more_stop;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rxd_m <= 1'b1;
      rxd_s <= 1'b1;
      rxd_d <= 1'b1;
    end else begin
      rxd_m <= rxd;
      rxd_s <= rxd_m;
      rxd_d <= rxd_s;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state        <= s_idle;
      tick_cnt     <= '0;
      bit_cnt      <= '0;
      stop_cnt     <= 1'b0;
      par_acc      <= 1'b0;
      par_err      <= 1'b0;
      stop_err     <= 1'b0;
      rx_done      <= 1'b0;
      data_valid   <= 1'b0;
      frame_error  <= 1'b0;
      parity_error <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      if (os_tick && state != s_idle) tick_cnt <= tick_cnt + 1'b1;
      case (state)
        s_idle: if (rx_en && rxd_d && !rxd_s) begin  // falling edge
          state    <= s_start;
          tick_cnt <= '0;
        end
        s_start: if (os_tick && tick_cnt == 4'd7) begin
          tick_cnt <= '0;
          bit_cnt  <= '0;
          stop_cnt <= 1'b0;
          par_acc  <= 1'b0;
          par_err  <= 1'b0;
          stop_err <= 1'b0;
          state    <= rxd_s ? s_idle : s_data;  // high here means a glitch
        end
        s_data: if (bit_end) begin
          par_acc <= par_acc ^ rxd_s;
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) state <= par_on ? s_parity : s_stop;
        end
        s_parity: if (bit_end) begin
          par_err <= (rxd_s != par_exp);
          state   <= s_stop;
        end
        s_stop: begin
          if (rx_done) begin
            state <= s_idle;
          end else if (bit_end && more_stop) begin
            stop_cnt <= 1'b1;
            stop_err <= !rxd_s;
          end else if (last_stop) begin
            rx_done      <= 1'b1;  // status moves with the strobe
            frame_error  <= stop_bad;
            parity_error <= par_err;
            data_valid   <= !stop_bad && !par_err;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  // data path, LSB first
  always_ff @(posedge clock) begin
    if (state == s_data && bit_end) shreg <= {rxd_s, shreg[7:1]};
    if (last_stop) rx_byte <= shreg;
  end

  a_done_in_stop: assert property (@(posedge clock) disable iff (!arst_n)
    rx_done |-> state == s_stop);

endmodule

// ==== src/baud_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// oversampling tick generator
// one clock wide pulse at 16x the baud rate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module baud_gen (
  input  logic clock,
  input  logic arst_n,
  output logic os_tick
);

  import uart_pkg::*;

  logic [os_cw-1:0] cnt;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      cnt     <= '0;
      os_tick <= 1'b0;
    end else if (cnt == os_cw'(os_div - 1)) begin
      cnt     <= '0;
      os_tick <= 1'b1;  // pulse at the wrap
    end else begin
      cnt     <= cnt + 1'b1;
      os_tick <= 1'b0;
    end
  end

endmodule

// ==== src/uart_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart echo shared definitions
// baud timing, echo queue sizing and the
// data types that cross module boundaries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package uart_pkg;

  // baud timing
  localparam int clk_hz  = 50_000_000;
  localparam int baud    = 9600;
  localparam int os_rate = 16;  // ticks per bit
  // rounded to the nearest whole cycle
  localparam int os_div  = (clk_hz + (baud * os_rate) / 2) / (baud * os_rate);
  localparam int os_cw   = $clog2(os_div);  // tick counter width

  // echo queue
  localparam int fifo_depth = 4;
  localparam int fifo_aw    = $clog2(fifo_depth);

  typedef logic [7:0] byte_t;
  typedef logic [7:0] seg_t;     // active low with bit 7 as the dp
  typedef logic [1:0] parity_t;  // 0/1 none, 2 even, 3 odd

  localparam parity_t par_even = 2'd2;
  localparam parity_t par_odd  = 2'd3;

endpackage
